// File: filelist.f
common/cpu_params_pkg.sv
common/uop_types_pkg.sv
mem_rs/mem_rs.sv
verilog/phys_regfile.sv
verilog/pipe_reg.sv
verilog/mem_agu.sv
verilog/mem_issue_top.sv
tests/tb_mem_issue.sv

// File: tests/tb_mem_issue.sv
module tb_mem_issue;
    timeunit 1ns;
    timeprecision 1ps;

    import cpu_params_pkg::*;
    import uop_types_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int DRIVE_DELAY  = 2;
    // 24 ready, 4 wakeup, 8 fill, 16 stall
    localparam int NUM_DISPATCH = 52;
    localparam int ROB_COUNT    = 1 << ROB_IDX;

    logic     clk;
    logic     rst;
    logic     dispatch_valid;
    logic     dispatch_ready;
    uop_t     dispatch_uop;
    cdb_t     cdb [CDB_WIDTH];
    logic     mem_req_valid;
    logic     mem_req_ready;
    mem_req_t mem_req;

    ////////////////////
    // reference state
    ////////////////////

    // last broadcast value per physical register
    logic [XLEN-1:0]      reg_model   [NUM_PHY_REGS];
    logic                 reg_written [NUM_PHY_REGS];
    // dispatched micro-ops by rob tag
    uop_t                 sb_uop      [ROB_COUNT];
    logic [ROB_COUNT-1:0] pending;
    logic [ROB_IDX-1:0]   next_rob;

    integer seed = 32'ha5e7;
    int     disp_count;
    int     left_count;
    int     value_errs;
    int     flow_errs;
    int     ready_mode;
    logic   expect_full;

    // expectation for whatever sits on mem_req, refreshed mid-cycle
    mem_req_t exp_req;
    logic     exp_pending;
    logic     exp_woken;

    mem_issue_top u_dut (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_ready (dispatch_ready),
        .dispatch_uop   (dispatch_uop),
        .cdb            (cdb),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_req        (mem_req)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////
    // expected request
    ////////////////////

    function automatic mem_req_t calc_req(input uop_t u);
        mem_req_t        r;
        logic [XLEN-1:0] base;
        int              size;
        int              off;
        if (u.op1_sel == OP1_PC) begin
            base = u.pc;
        end else if (u.op1_sel == OP1_RS1) begin
            base = reg_model[u.rs1_phy];
        end else begin
            base = '0;
        end
        r.rob_id = u.rob_id;
        r.rd_phy = u.rd_phy;
        r.mem_op = u.mem_op;
        r.addr   = base + u.imm;
        r.wdata  = (u.op2_sel == OP2_RS2) ? reg_model[u.rs2_phy] : '0;
        case (u.mem_op)
            MEM_LB, MEM_LBU, MEM_SB: size = 1;
            MEM_LH, MEM_LHU, MEM_SH: size = 2;
            default:                 size = 4;
        endcase
        off = int'(r.addr[1:0]);
        // lanes covered by the access, clipped at lane 3
        for (int lane = 0; lane < 4; lane++) begin
            r.byte_mask[lane] = (lane >= off) && (lane < off + size);
        end
        r.misaligned = (off % size) != 0;
        return r;
    endfunction

    // every register source the op needs has been broadcast or was ready
    function automatic logic sources_woken(input uop_t u);
        logic ok1;
        logic ok2;
        ok1 = (u.op1_sel != OP1_RS1) || u.rs1_valid || reg_written[u.rs1_phy];
        ok2 = (u.op2_sel != OP2_RS2) || u.rs2_valid || reg_written[u.rs2_phy];
        return ok1 && ok2;
    endfunction

    task automatic report_mismatch(input mem_req_t exp, input mem_req_t act);
        if (exp.rob_id != act.rob_id) begin
            $display("mismatch rob_id: expected %h, actual %h", exp.rob_id, act.rob_id);
        end
        if (exp.rd_phy != act.rd_phy) begin
            $display("mismatch rd_phy: expected %h, actual %h", exp.rd_phy, act.rd_phy);
        end
        if (exp.mem_op != act.mem_op) begin
            $display("mismatch mem_op: expected %h, actual %h", exp.mem_op, act.mem_op);
        end
        if (exp.addr != act.addr) begin
            $display("mismatch addr: expected %h, actual %h", exp.addr, act.addr);
        end
        if (exp.wdata != act.wdata) begin
            $display("mismatch wdata: expected %h, actual %h", exp.wdata, act.wdata);
        end
        if (exp.byte_mask != act.byte_mask) begin
            $display("mismatch byte_mask: expected %h, actual %h",
                     exp.byte_mask, act.byte_mask);
        end
        if (exp.misaligned != act.misaligned) begin
            $display("mismatch misaligned: expected %h, actual %h",
                     exp.misaligned, act.misaligned);
        end
        value_errs++;
    endtask

    always @(negedge clk) begin
        exp_req     = calc_req(sb_uop[mem_req.rob_id]);
        exp_pending = pending[mem_req.rob_id];
        exp_woken   = sources_woken(sb_uop[mem_req.rob_id]);
    end

    // retire requests as they leave
    always @(posedge clk) begin
        if (!rst && mem_req_valid && mem_req_ready) begin
            pending[mem_req.rob_id] = 1'b0;
            left_count++;
        end
    end

    ////////////////////
    // checks
    ////////////////////

    a_reset_state: assert property (@(posedge clk) $fell(rst) |-> !mem_req_valid && dispatch_ready)
        else begin
            flow_errs++;
            $display("after reset the request port is busy or dispatch is not ready");
        end

    a_known_rob: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid |-> exp_pending)
        else begin
            flow_errs++;
            $display("request for rob %h that is not outstanding", $sampled(mem_req.rob_id));
        end

    a_woken: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid && exp_pending |-> exp_woken)
        else begin
            flow_errs++;
            $display("rob %h left before its source tag was broadcast",
                     $sampled(mem_req.rob_id));
        end

    a_req_match: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid && exp_pending |-> mem_req == exp_req)
        else report_mismatch($sampled(exp_req), $sampled(mem_req));

    // stalled request holds still
    a_hold: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
        else begin
            flow_errs++;
            $display("request changed or dropped while the port was stalled");
        end

    a_full: assert property (@(posedge clk) disable iff (rst)
        expect_full |-> !dispatch_ready)
        else begin
            flow_errs++;
            $display("dispatch is ready although every station entry is waiting");
        end

    ////////////////////
    // stimulus helpers
    ////////////////////

    task automatic next_cycle();
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    // drive one cdb cycle, tag 0 leaves a port idle
    task automatic broadcast(input logic [PHY_IDX-1:0] t0, input logic [PHY_IDX-1:0] t1);
        logic [PHY_IDX-1:0] tags [CDB_WIDTH];
        tags[0] = t0;
        tags[1] = t1;
        for (int k = 0; k < CDB_WIDTH; k++) begin
            cdb[k].valid  = (tags[k] != '0);
            cdb[k].rd_phy = tags[k];
            cdb[k].value  = $random(seed);
            if (cdb[k].valid) begin
                reg_model[tags[k]]   = cdb[k].value;
                reg_written[tags[k]] = 1'b1;
            end
        end
        next_cycle();
        for (int k = 0; k < CDB_WIDTH; k++) begin
            cdb[k] = '0;
        end
    endtask

    // tags a free rob id, then holds valid until accepted
    task automatic send_uop(input uop_t u_in);
        uop_t u;
        u = u_in;
        while (pending[next_rob]) begin
            next_cycle();
        end
        u.rob_id       = next_rob;
        next_rob       = next_rob + 1'b1;
        dispatch_valid = 1'b1;
        dispatch_uop   = u;
        @(posedge clk);
        while (!dispatch_ready) begin
            @(posedge clk);
        end
        sb_uop[u.rob_id]  = u;
        pending[u.rob_id] = 1'b1;
        disp_count++;
        #(DRIVE_DELAY);
        dispatch_valid = 1'b0;
    endtask

    task automatic drain();
        while (left_count < disp_count) begin
            next_cycle();
        end
    endtask

    // sources from the preloaded low registers, already valid
    function automatic uop_t ready_uop(input int i);
        uop_t u;
        u.rob_id    = '0;
        u.rd_phy    = PHY_IDX'($random(seed));
        u.rs1_phy   = PHY_IDX'({$random(seed)} % 32);
        u.rs1_valid = 1'b1;
        u.rs2_phy   = PHY_IDX'({$random(seed)} % 32);
        u.rs2_valid = 1'b1;
        u.op1_sel   = op1_sel_e'(i % 3);
        u.op2_sel   = op2_sel_e'((i / 3) % 3);
        u.mem_op    = mem_op_e'(i % 8);
        u.imm       = $random(seed);
        // low offset bits walk through all byte lanes
        u.imm[1:0]  = 2'(i);
        u.pc        = $random(seed);
        u.pc[1:0]   = 2'b00;
        return u;
    endfunction

    // nonzero tag marks that source as waiting on the cdb
    function automatic uop_t waiting_uop(input logic [PHY_IDX-1:0] t1,
                                         input logic [PHY_IDX-1:0] t2,
                                         input mem_op_e op);
        uop_t u;
        u        = ready_uop(int'(op));
        u.mem_op = op;
        if (t1 != '0) begin
            u.op1_sel   = OP1_RS1;
            u.rs1_phy   = t1;
            u.rs1_valid = 1'b0;
        end
        if (t2 != '0) begin
            u.op2_sel   = OP2_RS2;
            u.rs2_phy   = t2;
            u.rs2_valid = 1'b0;
        end
        return u;
    endfunction

    ////////////////////
    // sequences
    ////////////////////

    // 0 always ready, 1 random stalls, 2 held low
    initial begin
        mem_req_ready = 1'b1;
        forever begin
            next_cycle();
            case (ready_mode)
                1:       mem_req_ready = ($random(seed) & 3) != 0;
                2:       mem_req_ready = 1'b0;
                default: mem_req_ready = 1'b1;
            endcase
        end
    end

    initial begin
        rst            = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_uop   = '0;
        for (int k = 0; k < CDB_WIDTH; k++) begin
            cdb[k] = '0;
        end
        for (int r = 0; r < NUM_PHY_REGS; r++) begin
            reg_model[r]   = '0;
            reg_written[r] = 1'b0;
        end
        pending     = '0;
        next_rob    = '0;
        disp_count  = 0;
        left_count  = 0;
        value_errs  = 0;
        flow_errs   = 0;
        ready_mode  = 0;
        expect_full = 1'b0;
        repeat (3) @(posedge clk);
        #(DRIVE_DELAY);
        rst = 1'b0;
        next_cycle();

        // preload p1..p31, upper registers stay free for wakeup tags
        for (int r = 1; r <= 31; r += 2) begin
            broadcast(PHY_IDX'(r), (r < 31) ? PHY_IDX'(r + 1) : '0);
        end

        // every operand select and access size, sources ready
        for (int i = 0; i < 24; i++) begin
            send_uop(ready_uop(i));
        end
        drain();

        // wakeup through the cdb, nothing may leave early
        send_uop(waiting_uop(6'd32, 6'd0, MEM_LW));
        send_uop(waiting_uop(6'd0, 6'd33, MEM_SW));
        send_uop(waiting_uop(6'd34, 6'd35, MEM_SH));
        send_uop(waiting_uop(6'd36, 6'd36, MEM_SB));
        idle_cycles(6);
        broadcast(6'd32, 6'd0);
        idle_cycles(2);
        broadcast(6'd33, 6'd34);
        broadcast(6'd35, 6'd36);
        drain();

        // fill the station with waiting entries
        for (int j = 0; j < RS_DEPTH; j++) begin
            if (j % 2 == 0) begin
                send_uop(waiting_uop(PHY_IDX'(37 + j), 6'd0, mem_op_e'(j)));
            end else begin
                send_uop(waiting_uop(6'd0, PHY_IDX'(37 + j), mem_op_e'(j)));
            end
        end
        expect_full = 1'b1;
        idle_cycles(3);
        expect_full = 1'b0;
        for (int j = 0; j < RS_DEPTH; j += 2) begin
            broadcast(PHY_IDX'(37 + j), PHY_IDX'(38 + j));
        end
        drain();

        // back-pressure, then random stalls
        ready_mode = 2;
        for (int i = 0; i < 6; i++) begin
            send_uop(ready_uop(i + 3));
        end
        idle_cycles(5);
        ready_mode = 1;
        for (int i = 0; i < 10; i++) begin
            send_uop(ready_uop(i * 5));
        end
        ready_mode = 0;
        drain();
        idle_cycles(2);

        if (left_count != disp_count) begin
            flow_errs++;
            $display("%0d requests left for %0d dispatches", left_count, disp_count);
        end
        $display("requests %0d of %0d, value errors %0d, flow errors %0d",
                 left_count, disp_count, value_errs, flow_errs);
        if (value_errs == 0 && flow_errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // bound on the whole run
    initial begin
        repeat (NUM_DISPATCH * 40) @(posedge clk);
        $display("timeout: only %0d of %0d requests left before the watchdog fired",
                 left_count, disp_count);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: verilog/mem_issue_top.sv
module mem_issue_top (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    dispatch_valid,
    output logic                    dispatch_ready,
    input  uop_types_pkg::uop_t     dispatch_uop,

    input  uop_types_pkg::cdb_t     cdb [cpu_params_pkg::CDB_WIDTH],

    output logic                    mem_req_valid,
    input  logic                    mem_req_ready,
    output uop_types_pkg::mem_req_t mem_req
);
    import cpu_params_pkg::*;
    import uop_types_pkg::*;

    ////////////////////
    // wiring
    ////////////////////

    // station to register file
    logic [PHY_IDX-1:0] prf_rs1_phy;
    logic [PHY_IDX-1:0] prf_rs2_phy;
    logic [XLEN-1:0]    prf_rs1_value;
    logic [XLEN-1:0]    prf_rs2_value;

    // station to issue stage
    logic        issue_valid;
    logic        issue_ready;
    fu_agu_reg_t issue_payload;

    // issue stage through agu to request stage
    logic        agu_valid;
    logic        agu_ready;
    fu_agu_reg_t agu_uop;
    mem_req_t    agu_req;

    mem_rs u_rs (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_ready (dispatch_ready),
        .dispatch_uop   (dispatch_uop),
        .cdb            (cdb),
        .prf_rs1_phy    (prf_rs1_phy),
        .prf_rs2_phy    (prf_rs2_phy),
        .prf_rs1_value  (prf_rs1_value),
        .prf_rs2_value  (prf_rs2_value),
        .issue_valid    (issue_valid),
        .issue_ready    (issue_ready),
        .issue_payload  (issue_payload)
    );

    phys_regfile u_prf (
        .clk       (clk),
        .rst       (rst),
        .cdb       (cdb),
        .rs1_phy   (prf_rs1_phy),
        .rs2_phy   (prf_rs2_phy),
        .rs1_value (prf_rs1_value),
        .rs2_value (prf_rs2_value)
    );

    // first stage holds the operand-read result
    pipe_reg #(.payload_t(fu_agu_reg_t)) u_issue_reg (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (issue_valid),
        .in_ready  (issue_ready),
        .in_data   (issue_payload),
        .out_valid (agu_valid),
        .out_ready (agu_ready),
        .out_data  (agu_uop)
    );

    mem_agu u_agu (
        .uop_in (agu_uop),
        .req    (agu_req)
    );

    // second stage drives the memory port
    pipe_reg #(.payload_t(mem_req_t)) u_req_reg (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (agu_valid),
        .in_ready  (agu_ready),
        .in_data   (agu_req),
        .out_valid (mem_req_valid),
        .out_ready (mem_req_ready),
        .out_data  (mem_req)
    );

endmodule

// File: verilog/mem_agu.sv
module mem_agu (
    input  uop_types_pkg::fu_agu_reg_t uop_in,
    output uop_types_pkg::mem_req_t    req
);
    import cpu_params_pkg::*;
    import uop_types_pkg::*;

    logic [XLEN-1:0] base;
    logic [XLEN-1:0] addr;
    logic [3:0]      size_mask;
    logic            is_half;
    logic            is_word;

    // address base
    always_comb begin
        case (uop_in.op1_sel)
            OP1_PC:  base = uop_in.pc;
            OP1_RS1: base = uop_in.rs1_value;
            default: base = '0;
        endcase
    end

    assign addr = base + uop_in.imm;

    // access width from the op
    always_comb begin
        is_half = 1'b0;
        is_word = 1'b0;
        case (uop_in.mem_op)
            MEM_LH, MEM_LHU, MEM_SH: is_half = 1'b1;
            MEM_LW, MEM_SW:          is_word = 1'b1;
            default:                 ;
        endcase
        size_mask = is_word ? 4'b1111 : (is_half ? 4'b0011 : 4'b0001);
    end

    always_comb begin
        req.rob_id     = uop_in.rob_id;
        req.rd_phy     = uop_in.rd_phy;
        req.mem_op     = uop_in.mem_op;
        req.addr       = addr;
        // store data only when rs2 feeds it
        req.wdata      = (uop_in.op2_sel == OP2_RS2) ? uop_in.rs2_value : '0;
        // lanes past byte 3 fall off
        req.byte_mask  = size_mask << addr[1:0];
        req.misaligned = (is_half && addr[0]) || (is_word && addr[1:0] != 2'b00);
    end

endmodule

// File: verilog/pipe_reg.sv
module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,

    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,

    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);
    logic     valid_q;
    payload_t data_q;

    // empty, or the held item leaves this cycle
    assign in_ready = !valid_q || out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;
        end
    end

    // payload only moves on a transfer
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

    assign out_valid = valid_q;
    assign out_data  = data_q;

    // stalled output holds its item
    a_hold_stable: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

// File: verilog/phys_regfile.sv
module phys_regfile (
    input  logic                                clk,
    input  logic                                rst,

    input  uop_types_pkg::cdb_t                 cdb [cpu_params_pkg::CDB_WIDTH],

    input  logic [cpu_params_pkg::PHY_IDX-1:0]  rs1_phy,
    input  logic [cpu_params_pkg::PHY_IDX-1:0]  rs2_phy,
    output logic [cpu_params_pkg::XLEN-1:0]     rs1_value,
    output logic [cpu_params_pkg::XLEN-1:0]     rs2_value
);
    import cpu_params_pkg::*;

    logic [XLEN-1:0] regs [NUM_PHY_REGS];

    ////////////////////
    // write ports
    ////////////////////

    // one write per cdb port, p0 stays zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_PHY_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int k = 0; k < CDB_WIDTH; k++) begin
                if (cdb[k].valid && cdb[k].rd_phy != '0) begin
                    regs[cdb[k].rd_phy] <= cdb[k].value;
                end
            end
        end
    end

    ////////////////////
    // read ports
    ////////////////////

    // array value first, then same-cycle broadcast wins
    always_comb begin
        rs1_value = regs[rs1_phy];
        rs2_value = regs[rs2_phy];
        for (int k = 0; k < CDB_WIDTH; k++) begin
            if (cdb[k].valid && cdb[k].rd_phy == rs1_phy) begin
                rs1_value = cdb[k].value;
            end
            if (cdb[k].valid && cdb[k].rd_phy == rs2_phy) begin
                rs2_value = cdb[k].value;
            end
        end
        // hardwired zero
        if (rs1_phy == '0) begin
            rs1_value = '0;
        end
        if (rs2_phy == '0) begin
            rs2_value = '0;
        end
    end

    // each producer owns its tag, so two ports never share a target
    for (genvar a = 0; a < CDB_WIDTH; a++) begin : g_port_a
        for (genvar b = a + 1; b < CDB_WIDTH; b++) begin : g_port_b
            a_cdb_unique: assert property (@(posedge clk) disable iff (rst)
                !(cdb[a].valid && cdb[b].valid && cdb[a].rd_phy != '0
                  && cdb[a].rd_phy == cdb[b].rd_phy));
        end
    end

endmodule

// File: mem_rs/mem_rs.sv
module mem_rs (
    input  logic                                clk,
    input  logic                                rst,

    input  logic                                dispatch_valid,
    output logic                                dispatch_ready,
    input  uop_types_pkg::uop_t                 dispatch_uop,

    input  uop_types_pkg::cdb_t                 cdb [cpu_params_pkg::CDB_WIDTH],

    output logic [cpu_params_pkg::PHY_IDX-1:0]  prf_rs1_phy,
    output logic [cpu_params_pkg::PHY_IDX-1:0]  prf_rs2_phy,
    input  logic [cpu_params_pkg::XLEN-1:0]     prf_rs1_value,
    input  logic [cpu_params_pkg::XLEN-1:0]     prf_rs2_value,

    output logic                                issue_valid,
    input  logic                                issue_ready,
    output uop_types_pkg::fu_agu_reg_t          issue_payload
);
    import cpu_params_pkg::*;
    import uop_types_pkg::*;

    ////////////////////
    // entry storage
    ////////////////////

    uop_t              rs_q   [RS_DEPTH];
    logic [RS_DEPTH-1:0] free_q;

    // per-entry wakeup and readiness
    logic [RS_DEPTH-1:0] src1_hit;
    logic [RS_DEPTH-1:0] src2_hit;
    logic [RS_DEPTH-1:0] entry_rdy;

    // allocation and selection
    logic              alloc_en;
    logic [RS_IDX-1:0] alloc_idx;
    logic [RS_IDX-1:0] issue_idx;
    logic              issue_fire;
    uop_t              alloc_uop;

    ////////////////////
    // cdb wakeup
    ////////////////////

    always_comb begin
        alloc_uop = dispatch_uop;
        for (int i = 0; i < RS_DEPTH; i++) begin
            src1_hit[i] = 1'b0;
            src2_hit[i] = 1'b0;
            for (int k = 0; k < CDB_WIDTH; k++) begin
                if (cdb[k].valid && cdb[k].rd_phy == rs_q[i].rs1_phy) begin
                    src1_hit[i] = 1'b1;
                end
                if (cdb[k].valid && cdb[k].rd_phy == rs_q[i].rs2_phy) begin
                    src2_hit[i] = 1'b1;
                end
            end
        end
        // broadcast during the dispatch cycle is caught on the way in
        for (int k = 0; k < CDB_WIDTH; k++) begin
            if (cdb[k].valid && cdb[k].rd_phy == dispatch_uop.rs1_phy) begin
                alloc_uop.rs1_valid = 1'b1;
            end
            if (cdb[k].valid && cdb[k].rd_phy == dispatch_uop.rs2_phy) begin
                alloc_uop.rs2_valid = 1'b1;
            end
        end
    end

    // source ready: no register needed, stored valid, or tag on cdb now
    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            entry_rdy[i] = !free_q[i]
                && (rs_q[i].op1_sel != OP1_RS1 || rs_q[i].rs1_valid || src1_hit[i])
                && (rs_q[i].op2_sel != OP2_RS2 || rs_q[i].rs2_valid || src2_hit[i]);
        end
    end

    ////////////////////
    // alloc and select
    ////////////////////

    // lowest free entry takes the dispatch
    always_comb begin
        alloc_idx = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (free_q[i]) begin
                alloc_idx = RS_IDX'(i);
            end
        end
    end

    // lowest ready entry goes out
    always_comb begin
        issue_idx = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (entry_rdy[i]) begin
                issue_idx = RS_IDX'(i);
            end
        end
    end

    assign dispatch_ready = |free_q;
    assign alloc_en       = dispatch_valid && dispatch_ready;
    assign issue_valid    = |entry_rdy;
    assign issue_fire     = issue_valid && issue_ready;

    ////////////////////
    // state update
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            free_q <= '1;
        end else begin
            if (alloc_en) begin
                free_q[alloc_idx] <= 1'b0;
            end
            // issued slot is never the one being filled
            if (issue_fire) begin
                free_q[issue_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        // latch wakeups for occupied entries
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (!free_q[i] && src1_hit[i]) begin
                rs_q[i].rs1_valid <= 1'b1;
            end
            if (!free_q[i] && src2_hit[i]) begin
                rs_q[i].rs2_valid <= 1'b1;
            end
        end
        if (alloc_en) begin
            rs_q[alloc_idx] <= alloc_uop;
        end
    end

    ////////////////////
    // prf read, payload
    ////////////////////

    assign prf_rs1_phy = rs_q[issue_idx].rs1_phy;
    assign prf_rs2_phy = rs_q[issue_idx].rs2_phy;

    always_comb begin
        issue_payload.rob_id    = rs_q[issue_idx].rob_id;
        issue_payload.rd_phy    = rs_q[issue_idx].rd_phy;
        issue_payload.op1_sel   = rs_q[issue_idx].op1_sel;
        issue_payload.op2_sel   = rs_q[issue_idx].op2_sel;
        issue_payload.mem_op    = rs_q[issue_idx].mem_op;
        issue_payload.imm       = rs_q[issue_idx].imm;
        issue_payload.pc        = rs_q[issue_idx].pc;
        // values already carry same-cycle cdb forwarding
        issue_payload.rs1_value = prf_rs1_value;
        issue_payload.rs2_value = prf_rs2_value;
    end

    ////////////////////
    // checks
    ////////////////////

    // accepted dispatch lands in a free slot that is held afterwards
    a_dispatch_not_full: assert property (@(posedge clk) disable iff (rst)
        alloc_en |-> free_q[alloc_idx] ##1 !free_q[$past(alloc_idx)]);

    // issued slot was occupied and is released at the edge
    a_issue_occupied: assert property (@(posedge clk) disable iff (rst)
        issue_fire |-> !free_q[issue_idx] ##1 free_q[$past(issue_idx)]);

endmodule

// File: common/uop_types_pkg.sv
package uop_types_pkg;

    import cpu_params_pkg::*;

    ////////////////////
    // encodings
    ////////////////////

    // first operand source
    typedef enum logic [1:0] {
        OP1_ZERO,
        OP1_PC,
        OP1_RS1
    } op1_sel_e;

    // second operand source
    typedef enum logic [1:0] {
        OP2_ZERO,
        OP2_IMM,
        OP2_RS2
    } op2_sel_e;

    // loads first, then stores
    typedef enum logic [2:0] {
        MEM_LB,
        MEM_LH,
        MEM_LW,
        MEM_LBU,
        MEM_LHU,
        MEM_SB,
        MEM_SH,
        MEM_SW
    } mem_op_e;

    ////////////////////
    // payloads
    ////////////////////

    // renamed micro-op as held in the station
    typedef struct packed {
        logic [ROB_IDX-1:0] rob_id;
        logic [PHY_IDX-1:0] rd_phy;
        logic [PHY_IDX-1:0] rs1_phy;
        logic               rs1_valid;
        logic [PHY_IDX-1:0] rs2_phy;
        logic               rs2_valid;
        op1_sel_e           op1_sel;
        op2_sel_e           op2_sel;
        mem_op_e            mem_op;
        logic [XLEN-1:0]    imm;
        logic [XLEN-1:0]    pc;
    } uop_t;

    // one result broadcast
    typedef struct packed {
        logic               valid;
        logic [PHY_IDX-1:0] rd_phy;
        logic [XLEN-1:0]    value;
    } cdb_t;

    // issued micro-op with operand values attached
    typedef struct packed {
        logic [ROB_IDX-1:0] rob_id;
        logic [PHY_IDX-1:0] rd_phy;
        op1_sel_e           op1_sel;
        op2_sel_e           op2_sel;
        mem_op_e            mem_op;
        logic [XLEN-1:0]    imm;
        logic [XLEN-1:0]    pc;
        logic [XLEN-1:0]    rs1_value;
        logic [XLEN-1:0]    rs2_value;
    } fu_agu_reg_t;

    // request towards the memory side
    typedef struct packed {
        logic [ROB_IDX-1:0] rob_id;
        logic [PHY_IDX-1:0] rd_phy;
        mem_op_e            mem_op;
        logic [XLEN-1:0]    addr;
        logic [XLEN-1:0]    wdata;
        logic [3:0]         byte_mask;
        logic               misaligned;
    } mem_req_t;

endpackage

// File: common/cpu_params_pkg.sv
package cpu_params_pkg;

    ////////////////////
    // datapath
    ////////////////////

    // data and address width
    localparam int XLEN = 32;

    ////////////////////
    // rename state
    ////////////////////

    // physical register count and index width
    localparam int NUM_PHY_REGS = 64;
    localparam int PHY_IDX      = $clog2(NUM_PHY_REGS);

    // reorder buffer tag width
    localparam int ROB_IDX = 5;

    ////////////////////
    // issue resources
    ////////////////////

    // memory reservation station
    localparam int RS_DEPTH = 8;
    localparam int RS_IDX   = $clog2(RS_DEPTH);

    // result broadcast ports
    localparam int CDB_WIDTH = 2;

endpackage
